//--- source/dl_dfe_pkg.sv
// downlink antenna path definitions

package dl_dfe_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////

   localparam int SAMPLE_W    = 16;   // bits per i or q component
   localparam int ANT_ID_W    = 3;    // antenna index, up to 8 antennas
   localparam int FRAME_NUM_W = 8;    // running frame number
   localparam int DROP_CNT_W  = 8;    // saturating drop counter

   ////////////////////////////////////////////////////////////
   // sample and status types
   ////////////////////////////////////////////////////////////

   // one complex sample, i in the upper half of the word
   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i;   // in-phase
      logic signed [SAMPLE_W-1:0] q;   // quadrature
   } iq_sample_t;

   // status word sent with every output frame
   typedef struct packed {
      logic                   seq_err;     // antenna order broken in frame
      logic [FRAME_NUM_W-1:0] frame_num;   // gap here means dropped frames
   } frame_status_t;

   // a frame is iq_sample_t [N_ANTENNAS-1:0], sized per instance
   // index 0 holds antenna 0

endpackage : dl_dfe_pkg

//--- source/ant_s2p.sv
// antenna serial to parallel
`timescale 1ns/1ps

module ant_s2p
   import dl_dfe_pkg::*;
#(
   parameter int N_ANTENNAS = 4                       // antennas per frame, 2 to 8
) (
   input  logic                        clk_4x,
   input  logic                        resetn_4x,
   input  logic                        sample_valid,  // at most one per cycle
   input  iq_sample_t                  sample,        // interleaved antenna data
   input  logic [ANT_ID_W-1:0]         ant_id,        // antenna of this sample
   output logic                        frame_pulse,   // one cycle per frame
   output iq_sample_t [N_ANTENNAS-1:0] frame          // held until next pulse
);

   ////////////////////////////////////////////////////////////
   // declarations
   ////////////////////////////////////////////////////////////

   localparam logic [ANT_ID_W-1:0] LAST_ID = ANT_ID_W'(N_ANTENNAS - 1);

   iq_sample_t [N_ANTENNAS-2:0] hold_q;      // latest sample of antennas 0..N-2
   iq_sample_t [N_ANTENNAS-1:0] frame_d;     // frame as it would be latched now
   logic                        last_hit;    // last antenna sample this cycle

   assign last_hit = sample_valid && (ant_id == LAST_ID);   // closes the frame

   ////////////////////////////////////////////////////////////
   // per antenna hold registers
   ////////////////////////////////////////////////////////////

   // last antenna needs no hold, it goes straight to the frame
   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         hold_q <= '0;                              // missing antennas read 0
      end
      else begin
         for (int a = 0; a < N_ANTENNAS - 1; a++) begin
            if (sample_valid && (ant_id == ANT_ID_W'(a))) begin
               hold_q[a] <= sample;                 // out of range ids never match
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // frame assembly
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int a = 0; a < N_ANTENNAS - 1; a++) begin
         frame_d[a] = hold_q[a];                    // stale if antenna was skipped
      end
      frame_d[N_ANTENNAS-1] = sample;               // incoming last antenna
   end

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         frame <= '0;
      end
      else if (last_hit) begin
         frame <= frame_d;                          // whole frame in one edge
      end
   end

   ////////////////////////////////////////////////////////////
   // frame strobe
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         frame_pulse <= 1'b0;
      end
      else begin
         frame_pulse <= last_hit;                   // aligned with frame update
      end
   end

endmodule : ant_s2p

//--- source/ant_seq_check.sv
// antenna order checker
`timescale 1ns/1ps

module ant_seq_check
   import dl_dfe_pkg::*;
#(
   parameter int N_ANTENNAS = 4                 // antennas per frame, 2 to 8
) (
   input  logic                clk_4x,
   input  logic                resetn_4x,
   input  logic                sample_valid,   // same stream as the s2p
   input  logic [ANT_ID_W-1:0] ant_id,         // index under test
   output logic                frame_seq_err   // one cycle, with frame_pulse
);

   ////////////////////////////////////////////////////////////
   // declarations
   ////////////////////////////////////////////////////////////

   localparam logic [ANT_ID_W-1:0] LAST_ID = ANT_ID_W'(N_ANTENNAS - 1);

   logic [ANT_ID_W-1:0] exp_id_q;   // index the next sample should carry
   logic                err_q;      // sticky error for the open frame
   logic                is_last;    // sample closes the frame
   logic                mismatch;   // sample index not the expected one

   assign is_last  = sample_valid && (ant_id == LAST_ID);
   assign mismatch = sample_valid && (ant_id != exp_id_q);

   ////////////////////////////////////////////////////////////
   // order tracking
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         exp_id_q      <= '0;                         // frame starts at antenna 0
         err_q         <= 1'b0;
         frame_seq_err <= 1'b0;
      end
      else begin
         frame_seq_err <= 1'b0;                       // pulse only
         if (is_last) begin
            frame_seq_err <= err_q | mismatch;        // includes the last sample
            err_q         <= 1'b0;                    // fresh frame
            exp_id_q      <= '0;
         end
         else if (sample_valid) begin
            err_q    <= err_q | mismatch;             // once set, held to frame end
            exp_id_q <= ant_id + ANT_ID_W'(1);        // resync on the seen index
         end
      end
   end

endmodule : ant_seq_check

//--- source/frame_out_hs.sv
// frame output handshake
`timescale 1ns/1ps

module frame_out_hs
   import dl_dfe_pkg::*;
#(
   parameter int N_ANTENNAS = 4                         // antennas per frame, 2 to 8
) (
   input  logic                        clk_4x,
   input  logic                        resetn_4x,
   input  logic                        frame_pulse,    // frame complete
   input  iq_sample_t [N_ANTENNAS-1:0] frame,          // valid with frame_pulse
   input  logic                        frame_seq_err,  // valid with frame_pulse
   output logic                        out_req,        // four phase request
   input  logic                        out_ack,        // from consumer
   output iq_sample_t [N_ANTENNAS-1:0] out_frame,      // stable while out_req
   output frame_status_t               out_status,     // stable while out_req
   output logic [DROP_CNT_W-1:0]       drop_count      // saturates at all ones
);

   ////////////////////////////////////////////////////////////
   // declarations
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      S_IDLE,      // nothing offered
      S_REQ,       // out_req high, waiting for ack
      S_ACK_LOW    // req dropped, waiting for ack to return low
   } hs_state_t;

   hs_state_t              state_q;
   logic [FRAME_NUM_W-1:0] frame_num_q;   // number for the next frame_pulse
   logic                   idle;          // req low and ack low
   logic                   accept;        // frame taken this cycle

   assign out_req = (state_q == S_REQ);                // decoded from state
   assign idle    = !out_req && !out_ack;
   assign accept  = frame_pulse && idle;

   ////////////////////////////////////////////////////////////
   // handshake FSM and output latch
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         state_q    <= S_IDLE;
         out_frame  <= '0;
         out_status <= '0;
      end
      else begin
         case (state_q)
            S_REQ: begin
               if (out_ack) begin
                  state_q <= S_ACK_LOW;                // req falls next cycle
               end
            end
            default: begin
               // ack may drop in the same cycle a frame arrives
               if (accept) begin
                  out_frame  <= frame;
                  out_status <= '{seq_err: frame_seq_err, frame_num: frame_num_q};
                  state_q    <= S_REQ;                 // req one cycle after pulse
               end
               else if (!out_ack) begin
                  state_q <= S_IDLE;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // frame numbering and drop count
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         frame_num_q <= '0;
         drop_count  <= '0;
      end
      else begin
         if (frame_pulse) begin
            frame_num_q <= frame_num_q + FRAME_NUM_W'(1);  // dropped frames count too
         end
         if (frame_pulse && !idle && (drop_count != '1)) begin
            drop_count <= drop_count + DROP_CNT_W'(1);     // consumer still busy
         end
      end
   end

endmodule : frame_out_hs

//--- source/dl_dfe_ant_top.sv
// downlink antenna front end top
`timescale 1ns/1ps

module dl_dfe_ant_top
   import dl_dfe_pkg::*;
#(
   parameter int N_ANTENNAS = 4                         // antennas per frame, 2 to 8
) (
   input  logic                        clk_4x,
   input  logic                        resetn_4x,
   input  logic                        sample_valid,   // interleaved input stream
   input  iq_sample_t                  sample,
   input  logic [ANT_ID_W-1:0]         ant_id,
   output logic                        out_req,        // frame offered
   input  logic                        out_ack,
   output iq_sample_t [N_ANTENNAS-1:0] out_frame,
   output frame_status_t               out_status,
   output logic [DROP_CNT_W-1:0]       drop_count
);

   ////////////////////////////////////////////////////////////
   // internal wires
   ////////////////////////////////////////////////////////////

   logic                        frame_pulse;     // from s2p
   iq_sample_t [N_ANTENNAS-1:0] frame;           // from s2p
   logic                        frame_seq_err;   // from order checker

   ////////////////////////////////////////////////////////////
   // blocks
   ////////////////////////////////////////////////////////////

   ant_s2p #(.N_ANTENNAS(N_ANTENNAS)) ant_s2p_i (
      .clk_4x       (clk_4x),
      .resetn_4x    (resetn_4x),
      .sample_valid (sample_valid),
      .sample       (sample),
      .ant_id       (ant_id),
      .frame_pulse  (frame_pulse),
      .frame        (frame)
   );

   ant_seq_check #(.N_ANTENNAS(N_ANTENNAS)) ant_seq_check_i (
      .clk_4x        (clk_4x),
      .resetn_4x     (resetn_4x),
      .sample_valid  (sample_valid),   // watches the same stream
      .ant_id        (ant_id),
      .frame_seq_err (frame_seq_err)
   );

   frame_out_hs #(.N_ANTENNAS(N_ANTENNAS)) frame_out_hs_i (
      .clk_4x        (clk_4x),
      .resetn_4x     (resetn_4x),
      .frame_pulse   (frame_pulse),
      .frame         (frame),
      .frame_seq_err (frame_seq_err),
      .out_req       (out_req),
      .out_ack       (out_ack),
      .out_frame     (out_frame),
      .out_status    (out_status),
      .drop_count    (drop_count)
   );

endmodule : dl_dfe_ant_top

//--- dv/dl_dfe_ant_tb.sv
// downlink antenna front end testbench
`timescale 1ns/1ps

module dl_dfe_ant_tb
   import dl_dfe_pkg::*;
();

   localparam int N_ANTENNAS       = 4;
   localparam int SLOW_ACK_DELAY   = 6;                          // cycles before ack
   localparam int N_FRAMES         = 6 + 3 + 8;                  // all tests together
   localparam int FRAME_CYCLES_MAX = N_ANTENNAS + 2 * SLOW_ACK_DELAY + 16;
   localparam int WATCHDOG_CYCLES  = N_FRAMES * FRAME_CYCLES_MAX + 200;

   logic                        clk_4x;
   logic                        resetn_4x;
   logic                        sample_valid;
   iq_sample_t                  sample;
   logic [ANT_ID_W-1:0]         ant_id;
   logic                        out_req;
   logic                        out_ack;
   iq_sample_t [N_ANTENNAS-1:0] out_frame;
   frame_status_t               out_status;
   logic [DROP_CNT_W-1:0]       drop_count;

   logic [31:0] rng;                                 // xorshift state
   int          ack_delay;                           // consumer latency
   int          ack_wait;

   // reference model state
   iq_sample_t [N_ANTENNAS-1:0] hold_ref;            // last sample per antenna
   logic [ANT_ID_W-1:0]         exp_id;              // expected next index
   logic                        err_open;            // sticky order error
   logic                        pulse_ref;           // frame closed last edge
   iq_sample_t [N_ANTENNAS-1:0] frame_ref;
   logic                        err_ref;
   logic                        req_ref;             // expected out_req
   logic [FRAME_NUM_W-1:0]      num_ref;             // next frame number
   logic [DROP_CNT_W-1:0]       drops_ref;
   iq_sample_t [N_ANTENNAS-1:0] exp_frame;           // what out_frame must hold
   frame_status_t               exp_status;

   dl_dfe_ant_top #(.N_ANTENNAS(N_ANTENNAS)) dl_dfe_ant_top_i (
      .clk_4x       (clk_4x),
      .resetn_4x    (resetn_4x),
      .sample_valid (sample_valid),
      .sample       (sample),
      .ant_id       (ant_id),
      .out_req      (out_req),
      .out_ack      (out_ack),
      .out_frame    (out_frame),
      .out_status   (out_status),
      .drop_count   (drop_count)
   );

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_on_error();
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic drive_sample(input logic [ANT_ID_W-1:0] id);
      @(posedge clk_4x);
      rng = xorshift32(rng);
      sample_valid <= 1'b1;
      ant_id       <= id;
      sample       <= rng;                           // i upper, q lower half
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk_4x);
         sample_valid <= 1'b0;
      end
   endtask

   task automatic send_frame();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         drive_sample(ANT_ID_W'(a));
      end
   endtask

   // req must show up, then the handshake returns to idle
   task automatic wait_frame_out();
      @(posedge clk_4x);
      while (!out_req) @(posedge clk_4x);
      while (out_req || out_ack) @(posedge clk_4x);
   endtask

   ////////////////////////////////////////////////////////////
   // clock, consumer, watchdog
   ////////////////////////////////////////////////////////////

   initial begin : clock_gen
      clk_4x = 1'b0;
      forever #5 clk_4x = ~clk_4x;                   // 10 ns period
   end

   initial begin : consumer
      out_ack  <= 1'b0;
      ack_wait = 0;
      forever begin
         @(posedge clk_4x);
         if (out_req && !out_ack) begin
            if (ack_wait >= ack_delay) begin
               out_ack  <= 1'b1;
               ack_wait = 0;
            end
            else begin
               ack_wait = ack_wait + 1;
            end
         end
         else if (out_ack && !out_req) begin
            out_ack <= 1'b0;                         // four phase return
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk_4x);
      $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      stop_on_error();
   end

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   always @(posedge clk_4x) begin : ref_model
      iq_sample_t [N_ANTENNAS-1:0] nxt;
      logic                        bad;
      nxt = hold_ref;
      bad = sample_valid && (ant_id != exp_id);
      if (!resetn_4x) begin
         hold_ref   <= '0;
         exp_id     <= '0;
         err_open   <= 1'b0;
         pulse_ref  <= 1'b0;
         frame_ref  <= '0;
         err_ref    <= 1'b0;
         req_ref    <= 1'b0;
         num_ref    <= '0;
         drops_ref  <= '0;
         exp_frame  <= '0;
         exp_status <= '0;
      end
      else begin
         pulse_ref <= 1'b0;
         if (sample_valid && (ant_id < N_ANTENNAS)) begin
            nxt[ant_id] = sample;
            hold_ref    <= nxt;
         end
         if (sample_valid && (ant_id == ANT_ID_W'(N_ANTENNAS - 1))) begin
            frame_ref <= nxt;                        // skipped antennas stay stale
            err_ref   <= err_open | bad;
            err_open  <= 1'b0;
            exp_id    <= '0;
            pulse_ref <= 1'b1;
         end
         else if (sample_valid) begin
            err_open <= err_open | bad;
            exp_id   <= ant_id + ANT_ID_W'(1);       // resync after a jump
         end
         // handshake side, one cycle behind the frame close
         if (req_ref && out_ack) begin
            req_ref <= 1'b0;
         end
         if (pulse_ref) begin
            num_ref <= num_ref + FRAME_NUM_W'(1);
            if (!req_ref && !out_ack) begin
               req_ref    <= 1'b1;
               exp_frame  <= frame_ref;
               exp_status <= '{seq_err: err_ref, frame_num: num_ref};
            end
            else if (drops_ref != '1) begin
               drops_ref <= drops_ref + DROP_CNT_W'(1);   // busy, frame lost
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   reset_values: assert property (@(posedge clk_4x)
      $rose(resetn_4x) |-> !out_req && (drop_count == '0))
      else begin
         $display("out_req or drop_count not cleared by reset");
         stop_on_error();
      end

   req_matches: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      out_req == req_ref)
      else begin
         $display("Mismatch out_req expected %h actual %h",
                  $sampled(req_ref), $sampled(out_req));
         stop_on_error();
      end

   frame_matches: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      out_req |-> out_frame == exp_frame)
      else begin
         $display("Mismatch out_frame expected %h actual %h",
                  $sampled(exp_frame), $sampled(out_frame));
         stop_on_error();
      end

   status_matches: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      out_req |-> out_status == exp_status)
      else begin
         $display("Mismatch out_status expected %h actual %h",
                  $sampled(exp_status), $sampled(out_status));
         stop_on_error();
      end

   drops_match: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      drop_count == drops_ref)
      else begin
         $display("Mismatch drop_count expected %h actual %h",
                  $sampled(drops_ref), $sampled(drop_count));
         stop_on_error();
      end

   no_rise_on_ack: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      !out_req && out_ack |=> !out_req)
      else begin
         $display("out_req rose while out_ack was still high");
         stop_on_error();
      end

   held_while_req: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      out_req && !out_ack |=> $stable(out_frame) && $stable(out_status))
      else begin
         $display("out_frame or out_status changed while out_req was high");
         stop_on_error();
      end

   req_falls: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      out_req && out_ack |=> !out_req)
      else begin
         $display("out_req did not fall the cycle after out_ack rose");
         stop_on_error();
      end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   initial begin : stimulus
      resetn_4x    <= 1'b0;
      sample_valid <= 1'b0;
      sample       <= '0;
      ant_id       <= '0;
      rng          = 32'd27;                         // fixed seed
      ack_delay    = 0;
      repeat (2) @(posedge clk_4x);
      resetn_4x <= 1'b1;
      idle_cycles(2);

      // in order, fast consumer
      repeat (6) begin
         send_frame();
         idle_cycles(1);
         wait_frame_out();
      end

      // skipped antenna 1, repeated antenna 1, then a clean frame
      drive_sample(3'd0);
      drive_sample(3'd2);
      drive_sample(3'd3);
      idle_cycles(1);
      wait_frame_out();
      drive_sample(3'd0);
      drive_sample(3'd1);
      drive_sample(3'd1);
      drive_sample(3'd3);
      idle_cycles(1);
      wait_frame_out();
      send_frame();
      idle_cycles(1);
      wait_frame_out();

      // slow consumer against back to back frames
      ack_delay = SLOW_ACK_DELAY;
      repeat (8) send_frame();
      idle_cycles(3);
      while (out_req || out_ack) @(posedge clk_4x);
      idle_cycles(2);
      if (drops_ref == '0) begin
         $display("slow consumer run dropped no frames, drop path not reached");
         stop_on_error();
      end
      else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule : dl_dfe_ant_tb

//--- sources.f
source/dl_dfe_pkg.sv
source/ant_s2p.sv
source/ant_seq_check.sv
source/frame_out_hs.sv
source/dl_dfe_ant_top.sv
dv/dl_dfe_ant_tb.sv

//--- Bender.yml
package:
  name: dl_dfe_ant

sources:
  - files:
      - source/dl_dfe_pkg.sv
      - source/ant_s2p.sv
      - source/ant_seq_check.sv
      - source/frame_out_hs.sv
      - source/dl_dfe_ant_top.sv
  - target: test
    files:
      - dv/dl_dfe_ant_tb.sv
